// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= icache.f
TOP       ?= tb_icache
RTL_TOP   ?= icache
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/icache.sv ====
// read-only 2-way icache top; memory must return line beats in ascending order, last flagged
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache (
  input  wire                      i_clk,
  input  wire                      i_rst,
  // cpu side
  input  wire                      i_valid,
  input  wire icache_pkg::tag_t    i_tag,
  input  wire icache_pkg::index_t  i_index,
  input  wire icache_pkg::offset_t i_offset,
  output logic                     o_addr_ok,
  output logic                     o_data_ok,
  output icache_pkg::word_t        o_rdata,
  // memory side
  output logic                     o_rd_req,
  output icache_pkg::addr_t        o_rd_addr,
  input  wire                      i_rd_rdy,
  input  wire                      i_ret_valid,
  input  wire                      i_ret_last,
  input  wire icache_pkg::word_t   i_ret_data
);

  icache_pkg::index_t rd_index;
  icache_pkg::beat_t  word_sel;
  icache_pkg::tag_t   req_tag;
  icache_pkg::ways_t  fill_en;
  icache_pkg::beat_t  fill_beat;
  icache_pkg::word_t  fill_data;
  logic               hit;
  icache_pkg::word_t  hit_word;

  icache_pkg::ways_t  way_valid;                   // registered per-way outputs
  icache_pkg::tag_t   way_tag  [`ICACHE_WAYS];
  icache_pkg::word_t  way_word [`ICACHE_WAYS];

  icache_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_tag       (i_tag),
    .i_index     (i_index),
    .i_offset    (i_offset),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .o_rd_req    (o_rd_req),
    .o_rd_addr   (o_rd_addr),
    .i_rd_rdy    (i_rd_rdy),
    .i_ret_valid (i_ret_valid),
    .i_ret_last  (i_ret_last),
    .i_ret_data  (i_ret_data),
    .i_hit       (hit),
    .i_hit_word  (hit_word),
    .o_rd_index  (rd_index),
    .o_word_sel  (word_sel),
    .o_req_tag   (req_tag),
    .o_fill_en   (fill_en),
    .o_fill_beat (fill_beat),
    .o_fill_data (fill_data)
  );

  // --------------------------------------------------
  // way arrays
  // --------------------------------------------------
  for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
    icache_way u_way (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rd_index  (rd_index),
      .i_word_sel  (word_sel),
      .i_fill_en   (fill_en[g]),                   // one-hot victim
      .i_fill_beat (fill_beat),
      .i_fill_data (fill_data),
      .i_fill_tag  (req_tag),
      .o_valid     (way_valid[g]),
      .o_tag       (way_tag[g]),
      .o_word      (way_word[g])
    );
  end

  icache_hit_select u_hit_select (
    .i_req_tag  (req_tag),
    .i_valid    (way_valid),
    .i_tags     (way_tag),
    .i_words    (way_word),
    .o_hit      (hit),
    .o_hit_word (hit_word)
  );

endmodule

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
// icache FSM; no new request accepted during a miss and o_rd_addr only meaningful while o_rd_req is high
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_ctrl (
  input  wire                      i_clk,
  input  wire                      i_rst,
  // cpu side
  input  wire                      i_valid,
  input  wire icache_pkg::tag_t    i_tag,
  input  wire icache_pkg::index_t  i_index,
  input  wire icache_pkg::offset_t i_offset,
  output logic                     o_addr_ok,
  output logic                     o_data_ok,
  output icache_pkg::word_t        o_rdata,
  // memory side
  output logic                     o_rd_req,
  output icache_pkg::addr_t        o_rd_addr,
  input  wire                      i_rd_rdy,
  input  wire                      i_ret_valid,
  input  wire                      i_ret_last,
  input  wire icache_pkg::word_t   i_ret_data,
  // lookup result
  input  wire                      i_hit,
  input  wire icache_pkg::word_t   i_hit_word,
  // way control
  output icache_pkg::index_t       o_rd_index,
  output icache_pkg::beat_t        o_word_sel,
  output icache_pkg::tag_t         o_req_tag,
  output icache_pkg::ways_t        o_fill_en,
  output icache_pkg::beat_t        o_fill_beat,
  output icache_pkg::word_t        o_fill_data
);

  icache_pkg::ctrl_state_e state_q;
  icache_pkg::ctrl_state_e state_d;

  icache_pkg::tag_t   req_tag_q;                   // request buffer
  icache_pkg::index_t req_index_q;
  icache_pkg::beat_t  req_word_q;

  icache_pkg::beat_t  beat_q;                      // refill beat count
  icache_pkg::way_t   victim_q;                    // round-robin pointer

  icache_pkg::beat_t  in_word;
  logic               in_idle;
  logic               in_lookup;
  logic               in_miss_req;
  logic               in_refill;
  logic               accept;
  logic               ret_beat;
  logic               fill_done;

  assign in_word     = i_offset[`ICACHE_OFFSET_W-1 -: $bits(icache_pkg::beat_t)];
  assign in_idle     = (state_q == icache_pkg::st_idle);
  assign in_lookup   = (state_q == icache_pkg::st_lookup);
  assign in_miss_req = (state_q == icache_pkg::st_miss_req);
  assign in_refill   = (state_q == icache_pkg::st_refill);

  assign o_addr_ok = in_idle || (in_lookup && i_hit);
  assign accept    = o_addr_ok && i_valid;
  assign ret_beat  = in_refill && i_ret_valid;
  assign fill_done = ret_beat && i_ret_last;

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::st_idle: begin
        if (i_valid) state_d = icache_pkg::st_lookup;
      end
      icache_pkg::st_lookup: begin
        if (!i_hit) state_d = icache_pkg::st_miss_req;
        else if (!i_valid) state_d = icache_pkg::st_idle; // else stay for a pipelined hit
      end
      icache_pkg::st_miss_req: begin
        if (i_rd_rdy) state_d = icache_pkg::st_refill;
      end
      icache_pkg::st_refill: begin
        if (fill_done) state_d = icache_pkg::st_idle;
      end
      default: state_d = icache_pkg::st_idle;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= icache_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // request buffer loaded on every accept
  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_tag_q   <= i_tag;
      req_index_q <= i_index;
      req_word_q  <= in_word;
    end
  end

  // --------------------------------------------------
  // refill tracking
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      beat_q <= '0;
    end else if (in_miss_req && i_rd_rdy) begin
      beat_q <= '0;                                // line transfer starts
    end else if (ret_beat) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      victim_q <= '0;
    end else if (fill_done) begin
      victim_q <= victim_q + 1'b1;                 // wraps over all ways
    end
  end

  // way addressing follows the incoming request only when it is taken
  assign o_rd_index  = accept ? i_index : req_index_q;
  assign o_word_sel  = accept ? in_word : req_word_q;
  assign o_req_tag   = req_tag_q;

  assign o_fill_en   = ret_beat ? (icache_pkg::ways_t'(1) << victim_q) : '0;
  assign o_fill_beat = beat_q;
  assign o_fill_data = i_ret_data;

  // --------------------------------------------------
  // responses
  // --------------------------------------------------
  assign o_rd_req  = in_miss_req;
  assign o_rd_addr = {req_tag_q, req_index_q, {`ICACHE_OFFSET_W{1'b0}}}; // line aligned

  // critical word is forwarded as it arrives
  assign o_data_ok = (in_lookup && i_hit) || (ret_beat && (beat_q == req_word_q));
  assign o_rdata   = in_lookup ? i_hit_word : i_ret_data;

endmodule

`default_nettype wire

// ==== hw/icache_hit_select.sv ====
// combinational hit logic; assumes at most one way hits per set, else words are OR-merged
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_hit_select (
  input  wire icache_pkg::tag_t  i_req_tag,
  input  wire icache_pkg::ways_t i_valid,
  input  wire icache_pkg::tag_t  i_tags  [`ICACHE_WAYS],
  input  wire icache_pkg::word_t i_words [`ICACHE_WAYS],
  output logic                   o_hit,
  output icache_pkg::word_t      o_hit_word
);

  icache_pkg::ways_t way_hit;                      // per-way compare result

  // --------------------------------------------------
  // tag compare
  // --------------------------------------------------
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      way_hit[w] = i_valid[w] && (i_tags[w] == i_req_tag);
    end
  end

  assign o_hit = |way_hit;

  // --------------------------------------------------
  // AND-OR word merge
  // --------------------------------------------------
  always_comb begin
    o_hit_word = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      o_hit_word = o_hit_word | ({`ICACHE_WORD_W{way_hit[w]}} & i_words[w]);
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_pkg.sv ====
// shared types for the icache; widths come from icache_defines.svh, which must be on the include path
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0]            addr_t;   // byte address
  typedef logic [`ICACHE_WORD_W-1:0]            word_t;   // word / memory beat
  typedef logic [`ICACHE_TAG_W-1:0]             tag_t;    // addr[31:11]
  typedef logic [`ICACHE_INDEX_W-1:0]           index_t;  // set number
  typedef logic [`ICACHE_OFFSET_W-1:0]          offset_t; // byte in line
  typedef logic [$clog2(`ICACHE_LINE_BEATS)-1:0] beat_t;  // word in line
  typedef logic [$clog2(`ICACHE_WAYS)-1:0]      way_t;    // way number
  typedef logic [`ICACHE_WAYS-1:0]              ways_t;   // one bit per way

  // controller FSM
  typedef enum logic [1:0] {
    st_idle     = 2'd0,
    st_lookup   = 2'd1,
    st_miss_req = 2'd2,
    st_refill   = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_way.sv ====
// one icache way; reads have 1-cycle latency, and fill writes use the read index as set address
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_way (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire icache_pkg::index_t i_rd_index,
  input  wire icache_pkg::beat_t  i_word_sel,
  input  wire                     i_fill_en,
  input  wire icache_pkg::beat_t  i_fill_beat,
  input  wire icache_pkg::word_t  i_fill_data,
  input  wire icache_pkg::tag_t   i_fill_tag,
  output logic                    o_valid,
  output icache_pkg::tag_t        o_tag,
  output icache_pkg::word_t       o_word
);

  logic [`ICACHE_SETS-1:0] valid_q;                           // per-set valid
  icache_pkg::tag_t        tag_mem  [`ICACHE_SETS];
  icache_pkg::word_t       data_mem [`ICACHE_SETS][`ICACHE_LINE_BEATS];

  logic                    fill_last;

  assign fill_last = i_fill_en &&
                     (i_fill_beat == icache_pkg::beat_t'(`ICACHE_LINE_BEATS - 1));

  // --------------------------------------------------
  // writes
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= '0;
    end else if (fill_last) begin
      valid_q[i_rd_index] <= 1'b1;                            // line complete
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_en) begin
      data_mem[i_rd_index][i_fill_beat] <= i_fill_data;
    end
    if (fill_last) begin
      tag_mem[i_rd_index] <= i_fill_tag;
    end
  end

  // --------------------------------------------------
  // registered read
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= valid_q[i_rd_index];
    end
  end

  always_ff @(posedge i_clk) begin
    o_tag  <= tag_mem[i_rd_index];
    o_word <= data_mem[i_rd_index][i_word_sel];               // selected word only
  end

endmodule

`default_nettype wire

// ==== icache.f ====
+incdir+include
hw/icache_pkg.sv
hw/icache_way.sv
hw/icache_hit_select.sv
hw/icache_ctrl.sv
hw/icache.sv
testbench/icache_properties.sv
testbench/tb_icache.sv

// ==== include/icache_defines.svh ====
// fixed 2-way 4 KB geometry; widths below are derived by hand and must be kept consistent
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// --------------------------------------------------
// cache geometry
// --------------------------------------------------
`define ICACHE_WAYS        2   // ways per set
`define ICACHE_SETS        64  // sets per way
`define ICACHE_LINE_BEATS  4   // 64-bit words per 32-byte line

// --------------------------------------------------
// bus and field widths
// --------------------------------------------------
`define ICACHE_ADDR_W      32  // byte address
`define ICACHE_WORD_W      64  // cache word and memory beat
`define ICACHE_INDEX_W     6   // addr[10:5]
`define ICACHE_OFFSET_W    5   // addr[4:0]
`define ICACHE_TAG_W       21  // addr[31:11]

`endif

// ==== testbench/icache_properties.sv ====
// bound into icache; assumes at most one response outstanding beyond the current accept
`timescale 1ns/1ns
`default_nettype none

module icache_properties (
  input wire i_clk,
  input wire i_rst,
  input wire i_valid,
  input wire o_addr_ok,
  input wire o_data_ok,
  input wire o_rd_req,
  input wire i_rd_rdy,
  input wire i_ret_valid,
  input wire i_ret_last
);

  logic [1:0] pending_q;                           // accepted but not yet answered
  logic       miss_q;                              // line read in progress

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pending_q <= '0;
      miss_q    <= 1'b0;
    end else begin
      pending_q <= pending_q + {1'b0, i_valid && o_addr_ok} - {1'b0, o_data_ok};
      if (o_rd_req) miss_q <= 1'b1;
      else if (i_ret_valid && i_ret_last) miss_q <= 1'b0;
    end
  end

  // --------------------------------------------------
  // handshake rules
  // --------------------------------------------------
  rd_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rd_req && !i_rd_rdy |=> o_rd_req)
    else $error("o_rd_req dropped before i_rd_rdy");

  no_accept_in_miss: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rd_req || miss_q) |-> !o_addr_ok)
    else $error("o_addr_ok high during a miss");

  data_ok_needs_request: assert property (@(posedge i_clk) disable iff (i_rst)
    o_data_ok |-> (pending_q != 2'd0))
    else $error("o_data_ok without an outstanding request");

  rd_req_low_after_reset: assert property (@(posedge i_clk)
    i_rst |=> !o_rd_req)
    else $error("o_rd_req high after reset");

endmodule

bind icache icache_properties u_icache_properties (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_valid     (i_valid),
  .o_addr_ok   (o_addr_ok),
  .o_data_ok   (o_data_ok),
  .o_rd_req    (o_rd_req),
  .i_rd_rdy    (i_rd_rdy),
  .i_ret_valid (i_ret_valid),
  .i_ret_last  (i_ret_last)
);

`default_nettype wire

// ==== testbench/tb_icache.sv ====
// icache testbench; drives on falling edges, samples 1 ns later, stops at the first mismatch
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module tb_icache;

  localparam int CLK_PERIOD = 8;
  localparam int N_RANDOM   = 400;
  localparam int RESET_AT   = 200;                 // mid-test reset point
  localparam int WATCHDOG   = (N_RANDOM + 20) * 40 * CLK_PERIOD;
  localparam int MEM_IDLE   = 0;
  localparam int MEM_WAIT   = 1;
  localparam int MEM_BURST  = 2;

  logic i_clk, i_rst, i_valid, o_addr_ok, o_data_ok, o_rd_req;
  logic i_rd_rdy, i_ret_valid, i_ret_last;
  icache_pkg::tag_t    i_tag, req_tag;
  icache_pkg::index_t  i_index, req_index;
  icache_pkg::offset_t i_offset, req_offset;
  icache_pkg::word_t   o_rdata, i_ret_data;
  icache_pkg::addr_t   o_rd_addr, miss_line;
  logic                req_valid;

  bit                  m_valid [`ICACHE_WAYS][`ICACHE_SETS];  // reference model
  icache_pkg::tag_t    m_tag   [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::way_t    m_victim;
  icache_pkg::word_t   exp_word[$];                           // oldest first
  bit                  exp_hit[$];
  int                  exp_cyc[$];
  int  cyc, miss_cyc, mem_state, rdy_wait, beat_n, gap;
  bit  miss_pending;

  icache icache_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_valid (i_valid), .i_tag (i_tag),
    .i_index (i_index), .i_offset (i_offset), .o_addr_ok (o_addr_ok),
    .o_data_ok (o_data_ok), .o_rdata (o_rdata), .o_rd_req (o_rd_req),
    .o_rd_addr (o_rd_addr), .i_rd_rdy (i_rd_rdy), .i_ret_valid (i_ret_valid),
    .i_ret_last (i_ret_last), .i_ret_data (i_ret_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  task automatic end_in_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(icache_pkg::word_t got, icache_pkg::word_t exp, string what);
    if (got !== exp) begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_addr(icache_pkg::addr_t got, icache_pkg::addr_t exp, string what);
    if (got !== exp) begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_flag(bit got, bit exp, string what);
    if (got !== exp) begin
      $display("FAIL t=%0t %s: got %0d expected %0d", $time, what, got, exp);
      end_in_failure();
    end
  endtask

  // memory contents mixed from the whole word address
  function automatic icache_pkg::word_t mem_word(icache_pkg::addr_t a);
    return {a ^ 32'h5bd1e995, (a * 32'h9e3779b1) ^ (a >> 7)};
  endfunction

  function automatic icache_pkg::tag_t pool_tag(int unsigned k);
    return icache_pkg::tag_t'(k * 32'h0f31 + 32'h00a5);
  endfunction

  function automatic icache_pkg::index_t pool_set(int unsigned k);
    return icache_pkg::index_t'(k * 21);                      // sets 0, 21, 42, 63
  endfunction

  function automatic void clear_model();
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      for (int s = 0; s < `ICACHE_SETS; s++) m_valid[w][s] = 1'b0;
    end
    m_victim = '0;
  endfunction

  // returns the hit prediction; a miss fills the round-robin victim
  function automatic bit model_access(icache_pkg::tag_t t, icache_pkg::index_t x);
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (m_valid[w][x] && m_tag[w][x] == t) return 1'b1;
    end
    m_valid[m_victim][x] = 1'b1;
    m_tag[m_victim][x]   = t;
    m_victim             = m_victim + 1'b1;
    return 1'b0;
  endfunction

  task automatic check_cycle(bit accepted);
    bit hit;
    if (exp_hit.size() > 0 && exp_hit[0] && cyc == exp_cyc[0] + 1) begin
      check_flag(o_data_ok, 1'b1, "o_data_ok one cycle after a hit");
      check_flag(o_addr_ok, 1'b1, "o_addr_ok while a hit returns");
    end
    if (o_data_ok) begin
      check_flag(exp_word.size() > 0, 1'b1, "o_data_ok with a request outstanding");
      hit = exp_hit.pop_front();
      if (!hit) check_flag(miss_pending, 1'b0, "line read done before miss data");
      check_word(o_rdata, exp_word.pop_front(), "o_rdata");
      void'(exp_cyc.pop_front());
    end
    if (o_rd_req) begin
      check_flag(miss_pending, 1'b1, "o_rd_req only for a predicted miss");
      check_addr(o_rd_addr, miss_line, "o_rd_addr");
      if (mem_state == MEM_IDLE)
        check_flag(cyc == miss_cyc + 2, 1'b1, "o_rd_req two cycles after accept");
    end
    if (accepted) begin
      hit = model_access(i_tag, i_index);
      exp_hit.push_back(hit);
      exp_word.push_back(mem_word({i_tag, i_index, i_offset[4:3], 3'b000}));
      exp_cyc.push_back(cyc);
      if (!hit) begin
        miss_pending = 1'b1;
        miss_line    = {i_tag, i_index, {`ICACHE_OFFSET_W{1'b0}}};
        miss_cyc     = cyc;
      end
    end
  endtask

  // --------------------------------------------------
  // per-cycle drive, sample and memory responder
  // --------------------------------------------------
  task automatic step(output bit accepted);
    @(negedge i_clk);
    i_valid     = req_valid;
    i_tag       = req_tag;
    i_index     = req_index;
    i_offset    = req_offset;
    i_rd_rdy    = (mem_state == MEM_WAIT) && (rdy_wait == 0);
    i_ret_valid = (mem_state == MEM_BURST) && (gap == 0);
    i_ret_last  = i_ret_valid && (beat_n == `ICACHE_LINE_BEATS - 1);
    i_ret_data  = i_ret_valid ? mem_word(miss_line + icache_pkg::addr_t'(beat_n * 8))
                              : {$urandom, $urandom};          // junk between beats
    #1;
    accepted = i_valid && o_addr_ok;
    check_cycle(accepted);
    case (mem_state)
      MEM_IDLE: begin
        if (o_rd_req) begin
          mem_state = MEM_WAIT;
          rdy_wait  = $urandom_range(0, 4);
        end
      end
      MEM_WAIT: begin
        if (i_rd_rdy) begin
          mem_state    = MEM_BURST;
          beat_n       = 0;
          gap          = $urandom_range(0, 2);
          miss_pending = 1'b0;
        end else rdy_wait--;
      end
      default: begin
        if (i_ret_valid) begin
          beat_n++;
          gap = $urandom_range(0, 2);
          if (beat_n == `ICACHE_LINE_BEATS) mem_state = MEM_IDLE;
        end else gap--;
      end
    endcase
    cyc++;
  endtask

  task automatic issue(icache_pkg::tag_t t, icache_pkg::index_t x, icache_pkg::offset_t o);
    bit acc;
    req_valid  = 1'b1;
    req_tag    = t;
    req_index  = x;
    req_offset = o;
    acc        = 1'b0;
    while (!acc) step(acc);                        // held until o_addr_ok
    req_valid  = 1'b0;
  endtask

  task automatic drain();
    bit acc;
    req_valid = 1'b0;
    while (exp_word.size() > 0 || mem_state != MEM_IDLE) step(acc);
  endtask

  task automatic apply_reset();
    @(negedge i_clk);
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;
    clear_model();
    exp_word.delete();
    exp_hit.delete();
    exp_cyc.delete();
    mem_state    = MEM_IDLE;
    miss_pending = 1'b0;
    #1;
    check_flag(o_addr_ok, 1'b1, "o_addr_ok after reset");
    check_flag(o_data_ok, 1'b0, "o_data_ok after reset");
    check_flag(o_rd_req, 1'b0, "o_rd_req after reset");
  endtask

  initial begin
    bit acc;
    void'($urandom(91));
    i_rst       = 1'b0;
    i_valid     = 1'b0;
    i_tag       = '0;
    i_index     = '0;
    i_offset    = '0;
    i_rd_rdy    = 1'b0;
    i_ret_valid = 1'b0;
    i_ret_last  = 1'b0;
    i_ret_data  = '0;
    req_valid   = 1'b0;
    req_tag     = '0;
    req_index   = '0;
    req_offset  = '0;
    cyc         = 0;
    miss_cyc    = 0;
    rdy_wait    = 0;
    beat_n      = 0;
    gap         = 0;
    miss_line   = '0;
    apply_reset();
    issue(pool_tag(0), 5, 8);                      // cold miss
    issue(pool_tag(0), 5, 16);                     // back-to-back hits
    issue(pool_tag(0), 5, 24);
    issue(pool_tag(1), 5, 0);                      // fills the second way
    issue(pool_tag(2), 5, 8);                      // evicts tag 0
    issue(pool_tag(1), 5, 16);                     // kept line hits
    issue(pool_tag(0), 5, 0);                      // evicted line misses
    drain();
    for (int i = 0; i < N_RANDOM; i++) begin
      if (i == RESET_AT) begin
        drain();
        issue(pool_tag(1), 5, 0);                  // evicted earlier so it misses
        while (!o_rd_req) step(acc);               // reset lands during the line read
        apply_reset();
        issue(pool_tag(0), 5, 0);                  // cached before reset but misses now
      end
      if ($urandom_range(0, 3) == 0) repeat ($urandom_range(1, 3)) step(acc);
      issue(pool_tag($urandom_range(0, 2)), pool_set($urandom_range(0, 3)),
            icache_pkg::offset_t'($urandom));
    end
    drain();
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired before all requests completed");
    end_in_failure();
  end

endmodule

`default_nettype wire
